// File: rtl/alu.sv
`timescale 1ns/1ns

module alu (
    input  pipePkg::dataWord srcA,
    input  pipePkg::dataWord srcB,
    input  pipePkg::aluCtrl  aluControl,
    output pipePkg::dataWord result,
    output logic             zero
);
    import pipePkg::*;

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt = srcB[4:0];
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (aluControl)
            aluAdd: begin
                result = srcA + srcB;
            end
            aluSub: begin
                result = srcA - srcB;
            end
            aluAnd: begin
                result = srcA & srcB;
            end
            aluOr: begin
                result = srcA | srcB;
            end
            aluXor: begin
                result = srcA ^ srcB;
            end
            aluSlt: begin
                result = dataWord'(lessThan);
            end
            aluSll: begin
                result = srcA << shamt;
            end
            aluSrl: begin
                // Logical shift, zero fill
                result = srcA >> shamt;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branch compares use SUB, so zero means equal
    assign zero = (result == '0);

endmodule

// File: rtl/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteD,
    input  logic             aluSrcD,
    input  logic             memWriteD,
    input  logic             resultSrcD,
    input  logic             branchD,
    input  pipePkg::aluCtrl  aluControlD,
    input  pipePkg::regAddr  rs1D,
    input  pipePkg::regAddr  rs2D,
    input  pipePkg::regAddr  rdD,
    input  pipePkg::dataWord immExtD,
    input  pipePkg::dataWord pcD,
    output pipePkg::regAddr  readAddrA,
    output pipePkg::regAddr  readAddrB,
    input  pipePkg::dataWord readDataA,
    input  pipePkg::dataWord readDataB,
    output logic             regWriteE,
    output logic             aluSrcE,
    output logic             memWriteE,
    output logic             resultSrcE,
    output logic             branchE,
    output pipePkg::aluCtrl  aluControlE,
    output pipePkg::regAddr  rs1E,
    output pipePkg::regAddr  rs2E,
    output pipePkg::regAddr  rdE,
    output pipePkg::dataWord rd1E,
    output pipePkg::dataWord rd2E,
    output pipePkg::dataWord immExtE,
    output pipePkg::dataWord pcE,
    output pipePkg::dataWord pcPlus4E
);
    import pipePkg::*;

    // Register file is read in the decode cycle
    assign readAddrA = rs1D;
    assign readAddrB = rs2D;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteE   <= 1'b0;
            aluSrcE     <= 1'b0;
            memWriteE   <= 1'b0;
            resultSrcE  <= 1'b0;
            branchE     <= 1'b0;
            aluControlE <= aluAdd;
            rs1E        <= '0;
            rs2E        <= '0;
            rdE         <= '0;
            rd1E        <= '0;
            rd2E        <= '0;
            immExtE     <= '0;
            pcE         <= '0;
            pcPlus4E    <= '0;
        end else begin
            regWriteE   <= regWriteD;
            aluSrcE     <= aluSrcD;
            memWriteE   <= memWriteD;
            resultSrcE  <= resultSrcD;
            branchE     <= branchD;
            aluControlE <= aluControlD;
            rs1E        <= rs1D;
            rs2E        <= rs2D;
            rdE         <= rdD;
            rd1E        <= readDataA;
            rd2E        <= readDataB;
            immExtE     <= immExtD;
            pcE         <= pcD;
            // Return address travels with the instruction
            pcPlus4E    <= pcD + pcStep;
        end
    end

endmodule

// File: rtl/execCoreTop.sv
`timescale 1ns/1ns

module execCoreTop #(
    parameter int memDepth = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteD,
    input  logic             aluSrcD,
    input  logic             memWriteD,
    input  logic             resultSrcD,
    input  logic             branchD,
    input  pipePkg::aluCtrl  aluControlD,
    input  pipePkg::regAddr  rs1D,
    input  pipePkg::regAddr  rs2D,
    input  pipePkg::regAddr  rdD,
    input  pipePkg::dataWord immExtD,
    input  pipePkg::dataWord pcD,
    output logic             pcSrcE,
    output pipePkg::dataWord pcTargetE,
    output logic             regWriteW,
    output pipePkg::regAddr  rdW,
    output pipePkg::dataWord resultW
);
    import pipePkg::*;

    regAddr  readAddrA;
    regAddr  readAddrB;
    dataWord readDataA;
    dataWord readDataB;

    logic    regWriteE;
    logic    aluSrcE;
    logic    memWriteE;
    logic    resultSrcE;
    logic    branchE;
    aluCtrl  aluControlE;
    regAddr  rs1E;
    regAddr  rs2E;
    regAddr  rdE;
    dataWord rd1E;
    dataWord rd2E;
    dataWord immExtE;
    dataWord pcE;
    dataWord pcPlus4E;

    fwdSel   forwardAE;
    fwdSel   forwardBE;

    logic    regWriteM;
    logic    memWriteM;
    logic    resultSrcM;
    regAddr  rdM;
    dataWord writeDataM;
    dataWord aluResultM;

    // Writeback result is the register file write port
    regFile regFile_i (
        .clk       (clk),
        .rst       (rst),
        .readAddrA (readAddrA),
        .readAddrB (readAddrB),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (regWriteW),
        .writeAddr (rdW),
        .writeData (resultW)
    );

    decodeStage decodeStage_i (
        .clk         (clk),
        .rst         (rst),
        .regWriteD   (regWriteD),
        .aluSrcD     (aluSrcD),
        .memWriteD   (memWriteD),
        .resultSrcD  (resultSrcD),
        .branchD     (branchD),
        .aluControlD (aluControlD),
        .rs1D        (rs1D),
        .rs2D        (rs2D),
        .rdD         (rdD),
        .immExtD     (immExtD),
        .pcD         (pcD),
        .readAddrA   (readAddrA),
        .readAddrB   (readAddrB),
        .readDataA   (readDataA),
        .readDataB   (readDataB),
        .regWriteE   (regWriteE),
        .aluSrcE     (aluSrcE),
        .memWriteE   (memWriteE),
        .resultSrcE  (resultSrcE),
        .branchE     (branchE),
        .aluControlE (aluControlE),
        .rs1E        (rs1E),
        .rs2E        (rs2E),
        .rdE         (rdE),
        .rd1E        (rd1E),
        .rd2E        (rd2E),
        .immExtE     (immExtE),
        .pcE         (pcE),
        .pcPlus4E    (pcPlus4E)
    );

    forwardUnit forwardUnit_i (
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdM       (rdM),
        .rdW       (rdW),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .forwardAE (forwardAE),
        .forwardBE (forwardBE)
    );

    // Return address is not consumed past the memory stage
    executeStage executeStage_i (
        .clk         (clk),
        .rst         (rst),
        .regWriteE   (regWriteE),
        .aluSrcE     (aluSrcE),
        .memWriteE   (memWriteE),
        .resultSrcE  (resultSrcE),
        .branchE     (branchE),
        .aluControlE (aluControlE),
        .rdE         (rdE),
        .rd1E        (rd1E),
        .rd2E        (rd2E),
        .immExtE     (immExtE),
        .pcE         (pcE),
        .pcPlus4E    (pcPlus4E),
        .resultW     (resultW),
        .forwardAE   (forwardAE),
        .forwardBE   (forwardBE),
        .pcSrcE      (pcSrcE),
        .pcTargetE   (pcTargetE),
        .regWriteM   (regWriteM),
        .memWriteM   (memWriteM),
        .resultSrcM  (resultSrcM),
        .rdM         (rdM),
        .pcPlus4M    (),
        .writeDataM  (writeDataM),
        .aluResultM  (aluResultM)
    );

    memWritebackStage #(
        .memDepth (memDepth)
    ) memWritebackStage_i (
        .clk        (clk),
        .rst        (rst),
        .regWriteM  (regWriteM),
        .memWriteM  (memWriteM),
        .resultSrcM (resultSrcM),
        .rdM        (rdM),
        .writeDataM (writeDataM),
        .aluResultM (aluResultM),
        .regWriteW  (regWriteW),
        .rdW        (rdW),
        .resultW    (resultW)
    );

endmodule

// File: rtl/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteE,
    input  logic             aluSrcE,
    input  logic             memWriteE,
    input  logic             resultSrcE,
    input  logic             branchE,
    input  pipePkg::aluCtrl  aluControlE,
    input  pipePkg::regAddr  rdE,
    input  pipePkg::dataWord rd1E,
    input  pipePkg::dataWord rd2E,
    input  pipePkg::dataWord immExtE,
    input  pipePkg::dataWord pcE,
    input  pipePkg::dataWord pcPlus4E,
    input  pipePkg::dataWord resultW,
    input  pipePkg::fwdSel   forwardAE,
    input  pipePkg::fwdSel   forwardBE,
    output logic             pcSrcE,
    output pipePkg::dataWord pcTargetE,
    output logic             regWriteM,
    output logic             memWriteM,
    output logic             resultSrcM,
    output pipePkg::regAddr  rdM,
    output pipePkg::dataWord pcPlus4M,
    output pipePkg::dataWord writeDataM,
    output pipePkg::dataWord aluResultM
);
    import pipePkg::*;

    dataWord srcA;
    dataWord srcBFwd;
    dataWord srcB;
    dataWord aluResultE;
    logic    zeroE;

    // Three-way forwarding mux
    function automatic dataWord fwdMux(fwdSel sel, dataWord regVal);
        case (sel)
            fwdWb:   return resultW;
            fwdMem:  return aluResultM;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        srcA    = fwdMux(forwardAE, rd1E);
        srcBFwd = fwdMux(forwardBE, rd2E);
    end

    assign srcB = aluSrcE ? immExtE : srcBFwd;

    alu alu_i (
        .srcA       (srcA),
        .srcB       (srcB),
        .aluControl (aluControlE),
        .result     (aluResultE),
        .zero       (zeroE)
    );

    // Branch target and decision
    assign pcTargetE = pcE + immExtE;
    assign pcSrcE    = branchE & zeroE;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteM  <= 1'b0;
            memWriteM  <= 1'b0;
            resultSrcM <= 1'b0;
            rdM        <= '0;
            pcPlus4M   <= '0;
            writeDataM <= '0;
            aluResultM <= '0;
        end else begin
            regWriteM  <= regWriteE;
            memWriteM  <= memWriteE;
            resultSrcM <= resultSrcE;
            rdM        <= rdE;
            pcPlus4M   <= pcPlus4E;
            // Store data is the forwarded rs2 rather than the immediate
            writeDataM <= srcBFwd;
            aluResultM <= aluResultE;
        end
    end

endmodule

// File: rtl/forwardUnit.sv
`timescale 1ns/1ns

module forwardUnit (
    input  pipePkg::regAddr rs1E,
    input  pipePkg::regAddr rs2E,
    input  pipePkg::regAddr rdM,
    input  pipePkg::regAddr rdW,
    input  logic            regWriteM,
    input  logic            regWriteW,
    output pipePkg::fwdSel  forwardAE,
    output pipePkg::fwdSel  forwardBE
);
    import pipePkg::*;

    logic memValid;
    logic wbValid;

    // Register zero is never a producer
    assign memValid = regWriteM && (rdM != '0);
    assign wbValid  = regWriteW && (rdW != '0);

    // Younger producer in the memory stage wins
    function automatic fwdSel pickSource(regAddr rs);
        if (memValid && rdM == rs) begin
            return fwdMem;
        end
        if (wbValid && rdW == rs) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    always_comb begin
        forwardAE = pickSource(rs1E);
        forwardBE = pickSource(rs2E);
    end

endmodule

// File: rtl/memWritebackStage.sv
`timescale 1ns/1ns

module memWritebackStage #(
    parameter int memDepth = 64
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             regWriteM,
    input  logic             memWriteM,
    input  logic             resultSrcM,
    input  pipePkg::regAddr  rdM,
    input  pipePkg::dataWord writeDataM,
    input  pipePkg::dataWord aluResultM,
    output logic             regWriteW,
    output pipePkg::regAddr  rdW,
    output pipePkg::dataWord resultW
);
    import pipePkg::*;

    localparam int addrW = $clog2(memDepth);

    dataWord           mem [memDepth];
    logic [addrW-1:0]  memAddr;
    dataWord           readDataM;

    logic              resultSrcW;
    dataWord           aluResultW;
    dataWord           readDataW;

    // Word address from the low ALU result bits
    assign memAddr   = aluResultM[addrW-1:0];
    assign readDataM = mem[memAddr];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            mem[memAddr] <= writeDataM;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= 1'b0;
            rdW        <= '0;
            aluResultW <= '0;
            readDataW  <= '0;
        end else begin
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
            rdW        <= rdM;
            aluResultW <= aluResultM;
            readDataW  <= readDataM;
        end
    end

    // Loads take memory data
    assign resultW = resultSrcW ? readDataW : aluResultW;

endmodule

// File: rtl/pipePkg.sv
package pipePkg;

    localparam int dataW = 21;
    localparam int regAddrW = 5;
    localparam int numRegs = 2 ** regAddrW;

    // Operands, immediates, PCs and results
    typedef logic [dataW-1:0] dataWord;
    typedef logic [regAddrW-1:0] regAddr;

    typedef logic [2:0] aluCtrl;
    typedef logic [1:0] fwdSel;

    // ALU operation codes
    localparam aluCtrl aluAdd = 3'd0;
    localparam aluCtrl aluSub = 3'd1;
    localparam aluCtrl aluAnd = 3'd2;
    localparam aluCtrl aluOr  = 3'd3;
    localparam aluCtrl aluXor = 3'd4;
    // Signed compare, result is 1 or 0
    localparam aluCtrl aluSlt = 3'd5;
    localparam aluCtrl aluSll = 3'd6;
    localparam aluCtrl aluSrl = 3'd7;

    // Operand source for the execute stage
    localparam fwdSel fwdReg = 2'd0;
    localparam fwdSel fwdWb  = 2'd1;
    localparam fwdSel fwdMem = 2'd2;

    // Branch return address step
    localparam dataWord pcStep = dataWord'(4);

endpackage

// File: rtl/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  pipePkg::regAddr readAddrA,
    input  pipePkg::regAddr readAddrB,
    output pipePkg::dataWord readDataA,
    output pipePkg::dataWord readDataB,
    input  logic            writeEn,
    input  pipePkg::regAddr writeAddr,
    input  pipePkg::dataWord writeData
);
    import pipePkg::*;

    dataWord regs [numRegs];

    // Register zero reads zero and a same-cycle write passes through
    function automatic dataWord readPort(regAddr addr);
        if (addr == '0) begin
            return '0;
        end
        if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module execCoreTb -f sources.f -o execCoreSim \
    && ./obj_dir/execCoreSim > sim.log 2>&1 \
    || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "^TEST OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sources.f
rtl/pipePkg.sv
rtl/regFile.sv
rtl/alu.sv
rtl/forwardUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWritebackStage.sv
rtl/execCoreTop.sv
testbench/execCoreTb.sv

// File: testbench/execCoreTb.sv
`timescale 1ns/1ns

module execCoreTb;
    import pipePkg::*;

    localparam int memAddrW = 6;
    localparam int memDepth = 2 ** memAddrW;

    typedef struct packed {
        logic    regWrite;
        logic    aluSrc;
        logic    memWrite;
        logic    resultSrc;
        logic    branch;
        aluCtrl  op;
        regAddr  rs1;
        regAddr  rs2;
        regAddr  rd;
        dataWord imm;
        logic    rnd;
    } instrRow;

    logic    clk;
    logic    rst;
    logic    regWriteD;
    logic    aluSrcD;
    logic    memWriteD;
    logic    resultSrcD;
    logic    branchD;
    aluCtrl  aluControlD;
    regAddr  rs1D;
    regAddr  rs2D;
    regAddr  rdD;
    dataWord immExtD;
    dataWord pcD;
    logic    pcSrcE;
    dataWord pcTargetE;
    logic    regWriteW;
    regAddr  rdW;
    dataWord resultW;

    instrRow prog [$];
    dataWord modelRegs [32];
    dataWord modelMem [memDepth];
    regAddr  expRd [$];
    dataWord expResult [$];
    logic    expTaken [$];
    dataWord expTarget [$];

    // Tracks a branch row from decode into execute
    logic    branchInDecode;
    logic    branchInExec;
    int      errors = 0;
    int      wbChecks = 0;
    int      branchChecks = 0;

    execCoreTop #(
        .memDepth (memDepth)
    ) dut_i (
        .clk         (clk),
        .rst         (rst),
        .regWriteD   (regWriteD),
        .aluSrcD     (aluSrcD),
        .memWriteD   (memWriteD),
        .resultSrcD  (resultSrcD),
        .branchD     (branchD),
        .aluControlD (aluControlD),
        .rs1D        (rs1D),
        .rs2D        (rs2D),
        .rdD         (rdD),
        .immExtD     (immExtD),
        .pcD         (pcD),
        .pcSrcE      (pcSrcE),
        .pcTargetE   (pcTargetE),
        .regWriteW   (regWriteW),
        .rdW         (rdW),
        .resultW     (resultW)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic regOp(input aluCtrl op, input regAddr rd, input regAddr rs1, input regAddr rs2);
        instrRow r;
        r = '0;
        r.regWrite = 1'b1;
        r.op = op;
        r.rd = rd;
        r.rs1 = rs1;
        r.rs2 = rs2;
        prog.push_back(r);
    endtask

    task automatic immOp(input aluCtrl op, input regAddr rd, input regAddr rs1, input dataWord imm,
                         input logic rnd);
        instrRow r;
        r = '0;
        r.regWrite = 1'b1;
        r.aluSrc = 1'b1;
        r.op = op;
        r.rd = rd;
        r.rs1 = rs1;
        r.imm = imm;
        r.rnd = rnd;
        prog.push_back(r);
    endtask

    task automatic storeWord(input regAddr src, input regAddr base, input dataWord offset);
        instrRow r;
        r = '0;
        r.memWrite = 1'b1;
        r.aluSrc = 1'b1;
        r.op = aluAdd;
        r.rs1 = base;
        r.rs2 = src;
        r.imm = offset;
        prog.push_back(r);
    endtask

    task automatic loadWord(input regAddr rd, input regAddr base, input dataWord offset);
        instrRow r;
        r = '0;
        r.regWrite = 1'b1;
        r.resultSrc = 1'b1;
        r.aluSrc = 1'b1;
        r.op = aluAdd;
        r.rd = rd;
        r.rs1 = base;
        r.imm = offset;
        prog.push_back(r);
    endtask

    task automatic branchCmp(input regAddr rs1, input regAddr rs2, input dataWord offset,
                             input logic rnd);
        instrRow r;
        r = '0;
        r.branch = 1'b1;
        r.op = aluSub;
        r.rs1 = rs1;
        r.rs2 = rs2;
        r.imm = offset;
        r.rnd = rnd;
        prog.push_back(r);
    endtask

    task automatic bubble();
        prog.push_back('0);
    endtask

    task automatic buildProgram();
        immOp(aluAdd, 5'd1, 5'd0, 21'h001234, 1'b0);
        immOp(aluAdd, 5'd2, 5'd0, 21'h01F00D, 1'b0);
        immOp(aluAdd, 5'd3, 5'd0, 21'h1FFFF9, 1'b0);
        immOp(aluAdd, 5'd4, 5'd0, 21'h000005, 1'b0);
        bubble();
        bubble();
        bubble();
        regOp(aluAdd, 5'd5, 5'd1, 5'd2);
        regOp(aluSub, 5'd6, 5'd1, 5'd2);
        regOp(aluAnd, 5'd7, 5'd1, 5'd2);
        regOp(aluOr, 5'd8, 5'd1, 5'd2);
        regOp(aluXor, 5'd9, 5'd1, 5'd2);
        regOp(aluSlt, 5'd10, 5'd3, 5'd4);
        regOp(aluSll, 5'd11, 5'd1, 5'd4);
        regOp(aluSrl, 5'd12, 5'd2, 5'd4);
        regOp(aluSlt, 5'd13, 5'd4, 5'd3);
        immOp(aluAdd, 5'd14, 5'd1, '0, 1'b1);
        immOp(aluSub, 5'd15, 5'd2, '0, 1'b1);
        immOp(aluAnd, 5'd16, 5'd1, '0, 1'b1);
        immOp(aluOr, 5'd17, 5'd2, '0, 1'b1);
        immOp(aluXor, 5'd18, 5'd3, '0, 1'b1);
        immOp(aluSlt, 5'd19, 5'd3, '0, 1'b1);
        immOp(aluSll, 5'd20, 5'd1, '0, 1'b1);
        immOp(aluSrl, 5'd21, 5'd2, '0, 1'b1);
        // x0 write must not forward or land in the register file
        immOp(aluAdd, 5'd0, 5'd1, 21'h000055, 1'b0);
        regOp(aluOr, 5'd22, 5'd0, 5'd1);
        regOp(aluAdd, 5'd23, 5'd1, 5'd0);
        regOp(aluAdd, 5'd23, 5'd0, 5'd0);
        // Forwarding at distance 1 and 2 and write-through at 3
        immOp(aluAdd, 5'd24, 5'd1, 21'h000100, 1'b0);
        regOp(aluAdd, 5'd25, 5'd24, 5'd24);
        regOp(aluSub, 5'd26, 5'd25, 5'd24);
        regOp(aluXor, 5'd27, 5'd24, 5'd25);
        regOp(aluSll, 5'd28, 5'd25, 5'd4);
        regOp(aluSlt, 5'd29, 5'd26, 5'd27);
        regOp(aluSub, 5'd30, 5'd2, 5'd27);
        immOp(aluAdd, 5'd31, 5'd0, 21'h00ABCD, 1'b0);
        storeWord(5'd31, 5'd0, 21'h000008);
        loadWord(5'd7, 5'd0, 21'h000008);
        bubble();
        regOp(aluAdd, 5'd8, 5'd7, 5'd7);
        immOp(aluAdd, 5'd12, 5'd0, 21'h000010, 1'b0);
        storeWord(5'd2, 5'd12, 21'h000004);
        loadWord(5'd13, 5'd12, 21'h000004);
        bubble();
        storeWord(5'd13, 5'd0, 21'h000030);
        loadWord(5'd14, 5'd0, 21'h000030);
        bubble();
        regOp(aluXor, 5'd15, 5'd14, 5'd13);
        branchCmp(5'd1, 5'd1, 21'h000040, 1'b0);
        branchCmp(5'd1, 5'd2, '0, 1'b1);
        regOp(aluAdd, 5'd16, 5'd3, 5'd0);
        branchCmp(5'd16, 5'd3, 21'h1FFFF0, 1'b0);
        branchCmp(5'd0, 5'd0, '0, 1'b1);
        branchCmp(5'd15, 5'd0, 21'h000020, 1'b0);
    endtask

    function automatic dataWord readReg(regAddr addr);
        if (addr == 5'd0) begin
            return '0;
        end
        return modelRegs[addr];
    endfunction

    function automatic dataWord aluModel(aluCtrl op, dataWord a, dataWord b);
        case (op)
            aluAdd:  return a + b;
            aluSub:  return a - b;
            aluAnd:  return a & b;
            aluOr:   return a | b;
            aluXor:  return a ^ b;
            aluSlt:  return ($signed(a) < $signed(b)) ? 21'd1 : 21'd0;
            aluSll:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    // Runs one row in program order and queues what the DUT should produce
    task automatic executeModel(input instrRow r, input dataWord pc);
        dataWord a;
        dataWord b;
        dataWord storeVal;
        dataWord res;
        a = readReg(r.rs1);
        storeVal = readReg(r.rs2);
        b = r.aluSrc ? r.imm : storeVal;
        res = aluModel(r.op, a, b);
        if (r.branch) begin
            expTaken.push_back(a == b);
            expTarget.push_back(pc + r.imm);
        end
        if (r.memWrite) begin
            modelMem[res[memAddrW-1:0]] = storeVal;
        end
        if (r.resultSrc) begin
            res = modelMem[res[memAddrW-1:0]];
        end
        if (r.regWrite) begin
            expRd.push_back(r.rd);
            expResult.push_back(res);
            if (r.rd != 5'd0) begin
                modelRegs[r.rd] = res;
            end
        end
    endtask

    task automatic applyRow(input instrRow r, input dataWord pc);
        regWriteD <= r.regWrite;
        aluSrcD <= r.aluSrc;
        memWriteD <= r.memWrite;
        resultSrcD <= r.resultSrc;
        branchD <= r.branch;
        aluControlD <= r.op;
        rs1D <= r.rs1;
        rs2D <= r.rs2;
        rdD <= r.rd;
        immExtD <= r.imm;
        pcD <= pc;
        branchInDecode <= r.branch;
    endtask

    always @(posedge clk) begin
        branchInExec <= branchInDecode;
    end

    // Sampled mid-cycle and active through reset
    always @(negedge clk) begin
        if (regWriteW) begin
            if (expRd.size() == 0) begin
                $display("ERROR at %0t: write-back to x%0d that no instruction expects",
                         $time, rdW);
                errors++;
            end else begin
                wbChecks++;
                if (rdW !== expRd[0]) begin
                    $display("MISMATCH %0t rdW got %0d expected %0d", $time, rdW, expRd[0]);
                    errors++;
                end
                if (resultW !== expResult[0]) begin
                    $display("MISMATCH %0t resultW got %h expected %h", $time, resultW,
                             expResult[0]);
                    errors++;
                end
                void'(expRd.pop_front());
                void'(expResult.pop_front());
            end
        end
        if (branchInExec && expTaken.size() != 0) begin
            branchChecks++;
            if (pcSrcE !== expTaken[0]) begin
                $display("MISMATCH %0t pcSrcE got %b expected %b", $time, pcSrcE, expTaken[0]);
                errors++;
            end
            if (pcTargetE !== expTarget[0]) begin
                $display("MISMATCH %0t pcTargetE got %h expected %h", $time, pcTargetE,
                         expTarget[0]);
                errors++;
            end
            void'(expTaken.pop_front());
            void'(expTarget.pop_front());
        end else if (pcSrcE !== 1'b0) begin
            $display("ERROR at %0t: pcSrcE is high with no branch in execute", $time);
            errors++;
        end
    end

    initial begin
        instrRow r;
        dataWord pc;
        int waitCycles;
        void'($urandom(35553));
        rst = 1'b0;
        regWriteD = 1'b0;
        aluSrcD = 1'b0;
        memWriteD = 1'b0;
        resultSrcD = 1'b0;
        branchD = 1'b0;
        aluControlD = aluAdd;
        rs1D = '0;
        rs2D = '0;
        rdD = '0;
        immExtD = '0;
        pcD = '0;
        branchInDecode = 1'b0;
        branchInExec = 1'b0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        buildProgram();
        repeat (16) @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        pc = 21'h001000;
        foreach (prog[i]) begin
            r = prog[i];
            if (r.rnd) begin
                r.imm = dataWord'($urandom);
            end
            @(posedge clk);
            applyRow(r, pc);
            executeModel(r, pc);
            pc = pc + 21'd4;
        end
        @(posedge clk);
        applyRow('0, pc);
        waitCycles = 0;
        while ((expRd.size() != 0 || expTaken.size() != 0) && waitCycles < 50) begin
            @(posedge clk);
            waitCycles++;
        end
        if (expRd.size() != 0 || expTaken.size() != 0) begin
            $display("ERROR: timeout, %0d write-backs and %0d branch results never arrived",
                     expRd.size(), expTaken.size());
            errors++;
        end
        repeat (2) @(negedge clk);
        $display("Write-back checks %0d, branch checks %0d, errors %0d", wbChecks,
                 branchChecks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
